//--- scd_cfg.svh
`ifndef SCD_CFG_SVH
`define SCD_CFG_SVH

// Shift count and exponent datapath widths.
// All words are numbered with bit 0 as the most significant bit

// SCAD adder, FE and SC width
`define SCD_EXP_WIDTH 10

// Full AR word
`define SCD_AR_WIDTH 36

// Microcode MAGIC number field
`define SCD_MAGIC_WIDTH 9

// Shift counts from this value up are past the end of a word
`define SCD_SC_LIMIT 36

`endif

//--- scdMicroPkg.sv
`include "scd_cfg.svh"

package scdMicroPkg;

  // SCAD function field, in microcode code order
  typedef enum logic [2:0] {
    FN_A                 = 3'd0,
    FN_A_MINUS_B_MINUS_1 = 3'd1,
    FN_A_PLUS_B          = 3'd2,
    FN_A_MINUS_1         = 3'd3,
    FN_A_PLUS_1          = 3'd4,
    FN_A_MINUS_B         = 3'd5,
    FN_OR                = 3'd6,
    FN_AND               = 3'd7
  } scadFuncT;

  typedef enum logic [1:0] {
    SCADA_FE       = 2'd0,
    SCADA_AR_SHORT = 2'd1,
    SCADA_AR_EXP   = 2'd2,
    SCADA_MAGIC    = 2'd3
  } scadaSelT;

  typedef enum logic [1:0] {
    SCADB_SC      = 2'd0,
    SCADB_AR_LOW  = 2'd1,
    SCADB_AR_HIGH = 2'd2,
    SCADB_MAGIC   = 2'd3
  } scadbSelT;

  typedef enum logic [1:0] {
    SC_HOLD = 2'd0,
    SC_FE   = 2'd1,
    SC_SCAD = 2'd2,
    SC_AR   = 2'd3
  } scSelT;

  // The SCD fields of one microinstruction
  typedef struct packed {
    scadFuncT                     func;
    scadaSelT                     scadaSel;
    logic                         scadaZero;
    scadbSelT                     scadbSel;
    logic                         feLoad;
    logic                         feShift;
    scSelT                        scSel;
    logic [0:`SCD_MAGIC_WIDTH-1]  magic;
  } scdCtlT;

endpackage

//--- scdDataPkg.sv
`include "scd_cfg.svh"

package scdDataPkg;

  // SCAD result, FE and SC
  typedef logic [0:`SCD_EXP_WIDTH-1] expWordT;

  // AR as seen by the exponent logic
  typedef logic [0:`SCD_AR_WIDTH-1] arWordT;

  // Status seen by the microcode condition logic.
  // The first two follow SCAD, the last two follow SC
  typedef struct packed {
    logic scadZero;
    logic scadSign;
    logic scGe36;
    logic sc36To63;
  } scdStatusT;

  // An SC value counts past a full word when either decode is set
  function automatic logic scPastWord(scdStatusT status);
    return status.scGe36 | status.sc36To63;
  endfunction

endpackage

//--- scadOperandMux.sv
`timescale 1ns/1ps

module scadOperandMux
  import scdMicroPkg::*, scdDataPkg::*;
(
  input  scdCtlT  ctl,
  input  arWordT  ar,
  input  expWordT fe,
  input  expWordT sc,
  output expWordT scadA,
  output expWordT scadB
);

  logic [0:7] arExpMag;
  expWordT    arShort;
  expWordT    arExp;
  expWordT    magicSigned;
  expWordT    arLow;
  expWordT    arHigh;
  expWordT    magicUnsigned;

  // Byte pointer position field, AR bits 0-5
  assign arShort = {4'b0000, ar[0:5]};

  // Floating exponent. A negative number holds its exponent in ones
  // complement, so the sign folds it back to a magnitude
  assign arExpMag = ar[1:8] ^ {8{ar[0]}};
  assign arExp    = {2'b00, arExpMag};

  // MAGIC is a signed 9 bit field on the A side
  assign magicSigned = {ctl.magic[0], ctl.magic};

  // Byte pointer size field, AR bits 6-11
  assign arLow = {4'b0000, ar[6:11]};

  // Raw exponent byte including the sign
  assign arHigh = {1'b0, ar[0:8]};

  assign magicUnsigned = {1'b0, ctl.magic};

  always_comb begin
    if (ctl.scadaZero) begin
      scadA = '0;
    end else begin
      case (ctl.scadaSel)
        SCADA_FE:       scadA = fe;
        SCADA_AR_SHORT: scadA = arShort;
        SCADA_AR_EXP:   scadA = arExp;
        SCADA_MAGIC:    scadA = magicSigned;
        default:        scadA = fe;
      endcase
    end
  end

  always_comb begin
    case (ctl.scadbSel)
      SCADB_SC:      scadB = sc;
      SCADB_AR_LOW:  scadB = arLow;
      SCADB_AR_HIGH: scadB = arHigh;
      SCADB_MAGIC:   scadB = magicUnsigned;
      default:       scadB = sc;
    endcase
  end

endmodule

//--- scadAlu.sv
`timescale 1ns/1ps
`include "scd_cfg.svh"

module scadAlu
  import scdMicroPkg::*, scdDataPkg::*;
(
  input  scadFuncT func,
  input  expWordT  scadA,
  input  expWordT  scadB,
  output expWordT  scad,
  output logic     scadZero,
  output logic     scadSign
);

  // One guard bit above bit 0 keeps the true sign when the 10 bit
  // result overflows
  logic [0:`SCD_EXP_WIDTH] aExt;
  logic [0:`SCD_EXP_WIDTH] bExt;
  logic [0:`SCD_EXP_WIDTH] result;

  assign aExt = {scadA[0], scadA};
  assign bExt = {scadB[0], scadB};

  always_comb begin
    case (func)
      FN_A: begin
        result = aExt;
      end
      FN_A_MINUS_B_MINUS_1: begin
        result = aExt + ~bExt;
      end
      FN_A_PLUS_B: begin
        result = aExt + bExt;
      end
      FN_A_MINUS_1: begin
        result = aExt - 1'b1;
      end
      FN_A_PLUS_1: begin
        result = aExt + 1'b1;
      end
      FN_A_MINUS_B: begin
        result = aExt - bExt;
      end
      FN_OR: begin
        result = aExt | bExt;
      end
      FN_AND: begin
        result = aExt & bExt;
      end
      default: begin
        result = aExt;
      end
    endcase
  end

  assign scad     = result[1:`SCD_EXP_WIDTH];
  assign scadSign = result[0];

  // Zero test looks at the 10 bit result only
  assign scadZero = (scad == '0);

endmodule

//--- feScRegs.sv
`timescale 1ns/1ps
`include "scd_cfg.svh"

module feScRegs
  import scdMicroPkg::*, scdDataPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  scdCtlT  ctl,
  input  expWordT scad,
  input  arWordT  ar,
  output expWordT fe,
  output expWordT sc,
  output logic    scGe36,
  output logic    sc36To63
);

  localparam logic [0:5] ScLimit = 6'(`SCD_SC_LIMIT);

  expWordT feNext;
  expWordT scNext;
  expWordT scFromAr;

  // FE load has priority over the arithmetic right shift
  always_comb begin
    if (ctl.feLoad) begin
      feNext = scad;
    end else if (ctl.feShift) begin
      feNext = {fe[0], fe[0:`SCD_EXP_WIDTH-2]};
    end else begin
      feNext = fe;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fe <= '0;
    end else begin
      fe <= feNext;
    end
  end

  // Shift count from the E field of an instruction. Bit 18 is the sign
  // and fills both top bits
  assign scFromAr = {{2{ar[18]}}, ar[28:35]};

  always_comb begin
    case (ctl.scSel)
      SC_HOLD: scNext = sc;
      SC_FE:   scNext = fe;
      SC_SCAD: scNext = scad;
      SC_AR:   scNext = scFromAr;
      default: scNext = sc;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sc <= '0;
    end else begin
      sc <= scNext;
    end
  end

  // Set for 64 and up or for a negative count
  assign scGe36 = |sc[0:3];

  // The low six bits at or above the limit, same as bit 4 with any of
  // bits 5-7. Only meaningful while scGe36 is clear
  assign sc36To63 = (sc[4:9] >= ScLimit);

endmodule

//--- scdCore.sv
`timescale 1ns/1ps

module scdCore
  import scdMicroPkg::*, scdDataPkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  scdCtlT    ctl,
  input  arWordT    ar,
  output expWordT   fe,
  output expWordT   sc,
  output expWordT   scad,
  output scdStatusT status
);

  expWordT scadA;
  expWordT scadB;
  logic    scadZero;
  logic    scadSign;
  logic    scGe36;
  logic    sc36To63;

  scadOperandMux scadOperandMux_inst (
    .ctl   (ctl),
    .ar    (ar),
    .fe    (fe),
    .sc    (sc),
    .scadA (scadA),
    .scadB (scadB)
  );

  scadAlu scadAlu_inst (
    .func     (ctl.func),
    .scadA    (scadA),
    .scadB    (scadB),
    .scad     (scad),
    .scadZero (scadZero),
    .scadSign (scadSign)
  );

  // FE and SC feed back into the operand selector
  feScRegs feScRegs_inst (
    .clk      (clk),
    .reset    (reset),
    .ctl      (ctl),
    .scad     (scad),
    .ar       (ar),
    .fe       (fe),
    .sc       (sc),
    .scGe36   (scGe36),
    .sc36To63 (sc36To63)
  );

  assign status = '{scadZero: scadZero, scadSign: scadSign,
                    scGe36: scGe36, sc36To63: sc36To63};

endmodule

//--- scdCore_checker.sv
`timescale 1ns/1ps

module scdCore_checker
  import scdDataPkg::*;
(
  input logic    clk,
  input logic    reset,
  input logic    feLoad,
  input logic    feShift,
  input expWordT fe,
  input expWordT sc,
  input logic    scGe36
);

  // Both registers come out of reset cleared
  resetClears: assert property (@(posedge clk) reset |=> (fe == '0 && sc == '0))
    else $error("FE or SC not cleared one cycle after reset");

  // With no load and no shift FE keeps its value
  feHolds: assert property (@(posedge clk) disable iff (reset)
    (!feLoad && !feShift) |=> $stable(fe))
    else $error("FE changed without load or shift");

  scGe36Decode: assert property (@(posedge clk) disable iff (reset)
    scGe36 == (|sc[0:3]))
    else $error("scGe36 does not match SC bits 0-3");

endmodule

bind scdCore scdCore_checker scdCore_checker_inst (
  .clk     (clk),
  .reset   (reset),
  .feLoad  (ctl.feLoad),
  .feShift (ctl.feShift),
  .fe      (fe),
  .sc      (sc),
  .scGe36  (status.scGe36)
);

//--- scdTb.sv
`timescale 1ns/1ps
`include "scd_cfg.svh"

module scdTb
  import scdMicroPkg::*, scdDataPkg::*;
();

  localparam int HalfPeriod   = 20;
  localparam int ResetCycles  = 2;
  localparam int SettleCycles = 4;
  localparam int FuncCycles   = 300;
  localparam int SourceCycles = 40;
  localparam int FeCycles     = 200;
  localparam int ScCycles     = 200;

  // Five SCADA cases and four SCADB cases of SourceCycles each
  localparam int CycleLimit = ResetCycles + SettleCycles + FuncCycles + 9 * SourceCycles
                              + FeCycles + ScCycles + 100;

  logic      clk;
  logic      reset;
  scdCtlT    ctl;
  arWordT    ar;
  expWordT   fe;
  expWordT   sc;
  expWordT   scad;
  scdStatusT status;

  // Reference copies of FE and SC
  expWordT feModel;
  expWordT scModel;

  integer seed;
  int     errorCount;
  int     checkCount;
  int     cycleCount;
  int     testStart;

  scdCore scdCore_inst (
    .clk    (clk),
    .reset  (reset),
    .ctl    (ctl),
    .ar     (ar),
    .fe     (fe),
    .sc     (sc),
    .scad   (scad),
    .status (status)
  );

  always #HalfPeriod clk = ~clk;

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycleCount);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    checkCount = checkCount + 1;
    if (actual !== expected) begin
      $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
      errorCount = errorCount + 1;
    end
  endtask

  task automatic reportTest(input string name, input int errors);
    $display("Test %s done with %0d mismatches", name, errors);
  endtask

  function automatic expWordT expectA(scdCtlT c, arWordT a, expWordT feV);
    expWordT result;
    if (c.scadaZero) begin
      result = '0;
    end else begin
      case (c.scadaSel)
        SCADA_FE:       result = feV;
        SCADA_AR_SHORT: result = {4'b0000, a[0:5]};
        SCADA_AR_EXP:   result = {2'b00, a[1:8] ^ {8{a[0]}}};
        default:        result = {c.magic[0], c.magic};
      endcase
    end
    return result;
  endfunction

  function automatic expWordT expectB(scdCtlT c, arWordT a, expWordT scV);
    expWordT result;
    case (c.scadbSel)
      SCADB_SC:      result = scV;
      SCADB_AR_LOW:  result = {4'b0000, a[6:11]};
      SCADB_AR_HIGH: result = {1'b0, a[0:8]};
      default:       result = {1'b0, c.magic};
    endcase
    return result;
  endfunction

  // Bit 0 of the return value is the sign of the 11 bit sum
  function automatic logic [0:10] aluModel(scadFuncT f, expWordT x, expWordT y);
    logic [0:10] ax;
    logic [0:10] bx;
    logic [0:10] r;
    ax = {x[0], x};
    bx = {y[0], y};
    case (f)
      FN_A:                 r = ax;
      FN_A_MINUS_B_MINUS_1: r = ax - bx - 11'd1;
      FN_A_PLUS_B:          r = ax + bx;
      FN_A_MINUS_1:         r = ax - 11'd1;
      FN_A_PLUS_1:          r = ax + 11'd1;
      FN_A_MINUS_B:         r = ax - bx;
      FN_OR:                r = ax | bx;
      default:              r = ax & bx;
    endcase
    return r;
  endfunction

  task automatic randomCtl(output scdCtlT c);
    c.func      = scadFuncT'(3'($random(seed)));
    c.scadaSel  = scadaSelT'(2'($random(seed)));
    c.scadaZero = 1'($random(seed));
    c.scadbSel  = scadbSelT'(2'($random(seed)));
    c.feLoad    = 1'($random(seed));
    c.feShift   = 1'($random(seed));
    c.scSel     = scSelT'(2'($random(seed)));
    c.magic     = 9'($random(seed));
  endtask

  task automatic randomAr(output arWordT a);
    logic [3:0]  hi;
    logic [31:0] lo;
    hi = 4'($random(seed));
    lo = $random(seed);
    a  = {hi, lo};
  endtask

  // One clock of stimulus. Registers are checked before the new drive,
  // the combinational outputs a few ns after it
  task automatic applyCycle(input scdCtlT c, input arWordT a);
    expWordT     expA;
    expWordT     expB;
    logic [0:10] expResult;
    expWordT     nextFe;
    expWordT     nextSc;
    @(negedge clk);
    checkValue(32'(fe), 32'(feModel), "fe");
    checkValue(32'(sc), 32'(scModel), "sc");
    ctl = c;
    ar  = a;
    #5;
    expA      = expectA(c, a, feModel);
    expB      = expectB(c, a, scModel);
    expResult = aluModel(c.func, expA, expB);
    checkValue(32'(scad), 32'(expResult[1:10]), "scad");
    checkValue(32'(status.scadZero), 32'(expResult[1:10] == 10'd0), "scadZero");
    checkValue(32'(status.scadSign), 32'(expResult[0]), "scadSign");
    checkValue(32'(status.scGe36), 32'(|scModel[0:3]), "scGe36");
    checkValue(32'(status.sc36To63), 32'(scModel[4] & (|scModel[5:7])), "sc36To63");
    if (c.feLoad) begin
      nextFe = expResult[1:10];
    end else if (c.feShift) begin
      nextFe = {feModel[0], feModel[0:8]};
    end else begin
      nextFe = feModel;
    end
    case (c.scSel)
      SC_HOLD: nextSc = scModel;
      SC_FE:   nextSc = feModel;
      SC_SCAD: nextSc = expResult[1:10];
      default: nextSc = {{2{a[18]}}, a[28:35]};
    endcase
    feModel = nextFe;
    scModel = nextSc;
  endtask

  initial begin
    scdCtlT c;
    arWordT a;
    int     sel;
    int     i;

    seed       = 32'h3922;
    errorCount = 0;
    checkCount = 0;
    cycleCount = 0;
    clk        = 1'b0;
    reset      = 1'b1;
    ctl        = '0;
    ar         = '0;
    feModel    = '0;
    scModel    = '0;

    testStart = errorCount;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    checkValue(32'(fe), 32'd0, "fe after reset");
    checkValue(32'(sc), 32'd0, "sc after reset");
    checkValue(32'(status.scGe36), 32'd0, "scGe36 after reset");
    checkValue(32'(status.sc36To63), 32'd0, "sc36To63 after reset");
    c = '0;
    a = '0;
    repeat (SettleCycles) applyCycle(c, a);
    reportTest("reset", errorCount - testStart);

    testStart = errorCount;
    for (i = 0; i < FuncCycles; i++) begin
      randomCtl(c);
      randomAr(a);
      c.scadaSel  = SCADA_FE;
      c.scadaZero = 1'b0;
      c.scadbSel  = SCADB_SC;
      applyCycle(c, a);
    end
    reportTest("SCAD functions", errorCount - testStart);

    testStart = errorCount;
    for (sel = 0; sel < 5; sel++) begin
      for (i = 0; i < SourceCycles; i++) begin
        randomCtl(c);
        randomAr(a);
        c.func = FN_A;
        // Case 4 keeps a random select with SCADA forced to zero
        if (sel < 4) begin
          c.scadaSel  = scadaSelT'(2'(sel));
          c.scadaZero = 1'b0;
        end else begin
          c.scadaZero = 1'b1;
        end
        applyCycle(c, a);
      end
    end
    reportTest("SCADA sources", errorCount - testStart);

    testStart = errorCount;
    for (sel = 0; sel < 4; sel++) begin
      for (i = 0; i < SourceCycles; i++) begin
        randomCtl(c);
        randomAr(a);
        c.func      = FN_A_PLUS_B;
        c.scadaZero = 1'b1;
        c.scadbSel  = scadbSelT'(2'(sel));
        applyCycle(c, a);
      end
    end
    reportTest("SCADB sources", errorCount - testStart);

    testStart = errorCount;
    for (i = 0; i < FeCycles; i++) begin
      randomCtl(c);
      randomAr(a);
      c.scSel = SC_HOLD;
      applyCycle(c, a);
    end
    reportTest("FE control", errorCount - testStart);

    testStart = errorCount;
    for (i = 0; i < ScCycles; i++) begin
      randomCtl(c);
      randomAr(a);
      applyCycle(c, a);
    end
    @(negedge clk);
    checkValue(32'(fe), 32'(feModel), "fe");
    checkValue(32'(sc), 32'(scModel), "sc");
    reportTest("SC control", errorCount - testStart);

    $display("Checks run: %0d, mismatches: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- scd.f
+incdir+.
scdMicroPkg.sv
scdDataPkg.sv
scadOperandMux.sv
scadAlu.sv
feScRegs.sv
scdCore.sv
scdCore_checker.sv
scdTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f scd.f --top-module scdTb -o scdSim \
  && ./obj_dir/scdSim | tee /dev/stderr | grep -qF '** PASS **' \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
